// ==== priv_pkg.sv ====
package priv_pkg;

	localparam int xlen = 32;

	// privilege levels, encoding 2 is reserved
	typedef enum logic [1:0] {
		U = 2'b00,
		S = 2'b01,
		M = 2'b11
	} mode_t;

	// same as funct3[1:0] of csrrw/csrrs/csrrc
	typedef enum logic [1:0] {
		CSR_RW = 2'b01,
		CSR_RS = 2'b10,
		CSR_RC = 2'b11
	} csr_op_t;

	// synchronous exception codes
	localparam logic [4:0] exc_i_addr_misaligned = 5'd0;
	localparam logic [4:0] exc_i_illegal         = 5'd2;
	localparam logic [4:0] exc_breakpoint        = 5'd3;
	localparam logic [4:0] exc_ecall_u           = 5'd8;
	localparam logic [4:0] exc_ecall_s           = 5'd9;
	localparam logic [4:0] exc_ecall_m           = 5'd11;

	// interrupt codes, also the bit positions in mip and mie
	localparam logic [4:0] irq_s_timer = 5'd5;
	localparam logic [4:0] irq_m_timer = 5'd7;
	localparam logic [4:0] irq_s_ext   = 5'd9;
	localparam logic [4:0] irq_m_ext   = 5'd11;

	// machine mode
	localparam logic [11:0] csr_mstatus  = 12'h300;
	localparam logic [11:0] csr_misa     = 12'h301;
	localparam logic [11:0] csr_medeleg  = 12'h302;
	localparam logic [11:0] csr_mideleg  = 12'h303;
	localparam logic [11:0] csr_mie      = 12'h304;
	localparam logic [11:0] csr_mtvec    = 12'h305;
	localparam logic [11:0] csr_mscratch = 12'h340;
	localparam logic [11:0] csr_mepc     = 12'h341;
	localparam logic [11:0] csr_mcause   = 12'h342;
	localparam logic [11:0] csr_mtval    = 12'h343;
	localparam logic [11:0] csr_mip      = 12'h344;
	localparam logic [11:0] csr_mcycle   = 12'hB00;
	localparam logic [11:0] csr_mhartid  = 12'hF14;

	// supervisor mode
	localparam logic [11:0] csr_sepc   = 12'h141;
	localparam logic [11:0] csr_scause = 12'h142;
	localparam logic [11:0] csr_stval  = 12'h143;

	// custom compare regs, checked against the low counter word
	localparam logic [11:0] csr_mtimecmp = 12'h7C0;
	localparam logic [11:0] csr_stimecmp = 12'h7C1;

	// MXL=1 (rv32), extensions I and S
	localparam logic [xlen-1:0] misa_value = 32'h4004_0100;

endpackage

// ==== csr_alu.sv ====
`timescale 1ns/1ps

module csr_alu (
	input  priv_pkg::csr_op_t op,
	input  logic [priv_pkg::xlen-1:0] operand,
	input  logic [priv_pkg::xlen-1:0] old_value,
	input  logic valid,
	output logic [priv_pkg::xlen-1:0] wdata,
	output logic wen
);

	logic op_known;
	logic zero_operand;
	logic no_write;

	assign zero_operand = (operand == '0);

	always_comb
	begin
		op_known = 1'b1;
		case (op)
			priv_pkg::CSR_RW: wdata = operand;
			priv_pkg::CSR_RS: wdata = old_value | operand;	// set bits
			priv_pkg::CSR_RC: wdata = old_value & ~operand;	// clear bits
			default:
			begin
				// undefined op leaves the csr alone
				wdata = old_value;
				op_known = 1'b0;
			end
		endcase
	end

	// csrrs/csrrc with a zero mask is a pure read
	assign no_write = (op != priv_pkg::CSR_RW) && zero_operand;

	assign wen = valid && op_known && !no_write;

endmodule

// ==== csr_timer.sv ====
`timescale 1ns/1ps

module csr_timer (
	input  logic clk,
	input  logic nrst,
	input  logic wr_en,
	input  logic [11:0] wr_addr,
	input  logic [priv_pkg::xlen-1:0] wr_data,
	output logic [priv_pkg::xlen-1:0] cycle,
	output logic m_timer,
	output logic s_timer
);

	logic [priv_pkg::xlen-1:0] mtimecmp;
	logic [priv_pkg::xlen-1:0] stimecmp;
	logic m_hit;
	logic s_hit;

	// pending once the counter reaches the compare value
	assign m_hit = (cycle >= mtimecmp);
	assign s_hit = (cycle >= stimecmp);

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			cycle    <= '0;
			mtimecmp <= '1;
			stimecmp <= '1;
			m_timer  <= 1'b0;
			s_timer  <= 1'b0;
		end
		else
		begin
			cycle   <= cycle + 1'b1;	// free running
			m_timer <= m_hit;		// pending one cycle after the match
			s_timer <= s_hit;
			if (wr_en && wr_addr == priv_pkg::csr_mtimecmp)
				mtimecmp <= wr_data;
			if (wr_en && wr_addr == priv_pkg::csr_stimecmp)
				stimecmp <= wr_data;
		end
	end

	// a parked compare never raises its pending bit
	assert property (@(posedge clk) disable iff (!nrst)
		$rose(m_timer) |-> $past(mtimecmp) != '1);

	assert property (@(posedge clk) disable iff (!nrst)
		$rose(s_timer) |-> $past(stimecmp) != '1);

endmodule

// ==== irq_select.sv ====
`timescale 1ns/1ps

module irq_select (
	input  logic [priv_pkg::xlen-1:0] mip,
	input  logic [priv_pkg::xlen-1:0] mie,
	input  logic [priv_pkg::xlen-1:0] mideleg,
	input  logic status_mie,
	input  logic status_sie,
	input  priv_pkg::mode_t current_mode,
	output logic irq_valid,
	output logic [priv_pkg::xlen-1:0] irq_cause,
	output logic irq_to_s
);

	logic [priv_pkg::xlen-1:0] pend;
	logic [priv_pkg::xlen-1:0] takeable;
	logic m_ok;
	logic s_ok;
	logic [4:0] code;

	assign pend = mip & mie;

	// M-level ints always preempt lower modes
	assign m_ok = (current_mode != priv_pkg::M) || status_mie;
	// delegated ones never interrupt M mode
	assign s_ok = (current_mode == priv_pkg::U) ||
		(current_mode == priv_pkg::S && status_sie);

	// each pending bit checked against the mode it is routed to
	assign takeable = pend & ((mideleg & {priv_pkg::xlen{s_ok}}) |
		(~mideleg & {priv_pkg::xlen{m_ok}}));

	// fixed priority MEI, MTI, SEI, STI
	always_comb
	begin
		irq_valid = 1'b1;
		if (takeable[priv_pkg::irq_m_ext])
			code = priv_pkg::irq_m_ext;
		else if (takeable[priv_pkg::irq_m_timer])
			code = priv_pkg::irq_m_timer;
		else if (takeable[priv_pkg::irq_s_ext])
			code = priv_pkg::irq_s_ext;
		else if (takeable[priv_pkg::irq_s_timer])
			code = priv_pkg::irq_s_timer;
		else
		begin
			irq_valid = 1'b0;
			code = '0;
		end
	end

	assign irq_cause = irq_valid ? {1'b1, 26'b0, code} : '0;	// interrupt flag in msb
	assign irq_to_s  = irq_valid && mideleg[code];

endmodule

// ==== csr_regfile.sv ====
`timescale 1ns/1ps

module csr_regfile (
	input  logic clk,
	input  logic nrst,
	input  logic [11:0] rd_addr,
	input  logic wr_en,
	input  logic [11:0] wr_addr,
	input  logic [priv_pkg::xlen-1:0] wr_data,
	input  logic exc_valid,
	input  logic [priv_pkg::xlen-1:0] exc_cause,
	input  logic [priv_pkg::xlen-1:0] exc_pc,
	input  logic mret,
	input  logic sret,
	input  logic irq_valid,
	input  logic [priv_pkg::xlen-1:0] irq_cause,
	input  logic irq_to_s,
	input  logic m_timer,
	input  logic s_timer,
	input  logic ext_m_irq,
	input  logic ext_s_irq,
	input  logic [priv_pkg::xlen-1:0] cycle,
	output logic [priv_pkg::xlen-1:0] rd_data,
	output logic [priv_pkg::xlen-1:0] mip,
	output logic [priv_pkg::xlen-1:0] mie,
	output logic [priv_pkg::xlen-1:0] mideleg,
	output logic status_mie,
	output logic status_sie,
	output priv_pkg::mode_t current_mode,
	output logic trap_busy,
	output logic trap_taken,
	output logic [priv_pkg::xlen-1:0] trap_pc
);

	// mstatus fields
	logic status_spie;
	logic status_mpie;
	logic status_spp;
	priv_pkg::mode_t status_mpp;

	// mie fields
	logic meie;
	logic seie;
	logic mtie;
	logic stie;

	logic [priv_pkg::xlen-1:2] mtvec;	// direct mode only
	logic [priv_pkg::xlen-1:0] mscratch;
	logic [priv_pkg::xlen-1:2] mepc;
	logic [priv_pkg::xlen-1:0] mcause;
	logic [priv_pkg::xlen-1:0] mtval;
	logic [15:0] medeleg;
	logic [11:0] mideleg_r;
	logic [priv_pkg::xlen-1:2] sepc;
	logic [priv_pkg::xlen-1:0] scause;
	logic [priv_pkg::xlen-1:0] stval;

	logic [priv_pkg::xlen-1:0] mstatus;
	priv_pkg::mode_t mpp_wr;

	logic take_exc;
	logic take_mret;
	logic take_sret;
	logic take_irq;
	logic enter_trap;
	logic exc_to_s;
	logic enter_s;
	logic [priv_pkg::xlen-1:0] trap_cause;
	logic [priv_pkg::xlen-1:0] trap_tval;

	assign mstatus = {19'b0, status_mpp, 2'b0, status_spp, status_mpie, 1'b0,
		status_spie, 1'b0, status_mie, 1'b0, status_sie, 1'b0};

	// pending bits come straight from the sources
	assign mip = {20'b0, ext_m_irq, 1'b0, ext_s_irq, 1'b0, m_timer, 1'b0, s_timer, 5'b0};
	assign mie = {20'b0, meie, 1'b0, seie, 1'b0, mtie, 1'b0, stie, 5'b0};
	assign mideleg = {20'b0, mideleg_r};

	// reserved mpp encoding falls back to U
	assign mpp_wr = (wr_data[12:11] == 2'b10) ? priv_pkg::U : priv_pkg::mode_t'(wr_data[12:11]);

	// exception first, then mret, sret, interrupt
	assign take_exc  = exc_valid;
	assign take_mret = !exc_valid && mret;
	assign take_sret = !exc_valid && !mret && sret;
	assign take_irq  = !exc_valid && !mret && !sret && irq_valid;

	assign trap_busy  = exc_valid || mret || sret || irq_valid;
	assign trap_taken = take_exc || take_mret || take_sret || take_irq;
	assign enter_trap = take_exc || take_irq;

	// medeleg only counts when trapping from below M
	assign exc_to_s = (current_mode != priv_pkg::M) &&
		(exc_cause[priv_pkg::xlen-1:4] == '0) && medeleg[exc_cause[3:0]];
	assign enter_s = take_exc ? exc_to_s : irq_to_s;

	assign trap_cause = take_exc ? exc_cause : irq_cause;
	// only a misaligned fetch reports its pc in tval
	assign trap_tval = (take_exc && exc_cause == priv_pkg::exc_i_addr_misaligned) ? exc_pc : '0;

	// redirect target, same cycle as the request
	always_comb
	begin
		if (take_mret)
			trap_pc = {mepc, 2'b00};
		else if (take_sret)
			trap_pc = {sepc, 2'b00};
		else
			trap_pc = {mtvec, 2'b00};
	end

	always_comb
	begin
		case (rd_addr)
			priv_pkg::csr_misa:     rd_data = priv_pkg::misa_value;
			priv_pkg::csr_mhartid:  rd_data = '0;	// single hart
			priv_pkg::csr_mstatus:  rd_data = mstatus;
			priv_pkg::csr_medeleg:  rd_data = {16'b0, medeleg};
			priv_pkg::csr_mideleg:  rd_data = mideleg;
			priv_pkg::csr_mie:      rd_data = mie;
			priv_pkg::csr_mtvec:    rd_data = {mtvec, 2'b00};
			priv_pkg::csr_mscratch: rd_data = mscratch;
			priv_pkg::csr_mepc:     rd_data = {mepc, 2'b00};
			priv_pkg::csr_mcause:   rd_data = mcause;
			priv_pkg::csr_mtval:    rd_data = mtval;
			priv_pkg::csr_mip:      rd_data = mip;
			priv_pkg::csr_sepc:     rd_data = {sepc, 2'b00};
			priv_pkg::csr_scause:   rd_data = scause;
			priv_pkg::csr_stval:    rd_data = stval;
			priv_pkg::csr_mcycle:   rd_data = cycle;
			default:                rd_data = '0;	// compare regs are write-only
		endcase
	end

	always_ff @(posedge clk or negedge nrst)
	begin
		if (!nrst)
		begin
			current_mode <= priv_pkg::M;
			status_sie   <= 1'b0;
			status_mie   <= 1'b0;
			status_spie  <= 1'b0;
			status_mpie  <= 1'b0;
			status_spp   <= 1'b0;
			status_mpp   <= priv_pkg::U;
			meie         <= 1'b0;
			seie         <= 1'b0;
			mtie         <= 1'b0;
			stie         <= 1'b0;
			mtvec        <= '0;
			mscratch     <= '0;
			mepc         <= '0;
			mcause       <= '0;
			mtval        <= '0;
			medeleg      <= '0;
			mideleg_r    <= '0;
			sepc         <= '0;
			scause       <= '0;
			stval        <= '0;
		end
		else if (enter_trap)
		begin
			if (enter_s)
			begin
				sepc         <= exc_pc[priv_pkg::xlen-1:2];	// interrupted pc rides on exc_pc
				scause       <= trap_cause;
				stval        <= trap_tval;
				status_spie  <= status_sie;
				status_sie   <= 1'b0;
				status_spp   <= (current_mode == priv_pkg::S);
				current_mode <= priv_pkg::S;
			end
			else
			begin
				mepc         <= exc_pc[priv_pkg::xlen-1:2];
				mcause       <= trap_cause;
				mtval        <= trap_tval;
				status_mpie  <= status_mie;
				status_mie   <= 1'b0;
				status_mpp   <= current_mode;
				current_mode <= priv_pkg::M;
			end
		end
		else if (take_mret)
		begin
			current_mode <= status_mpp;
			status_mie   <= status_mpie;
			status_mpie  <= 1'b1;
			status_mpp   <= priv_pkg::U;
		end
		else if (take_sret)
		begin
			current_mode <= status_spp ? priv_pkg::S : priv_pkg::U;
			status_sie   <= status_spie;
			status_spie  <= 1'b1;
			status_spp   <= 1'b0;
		end
		else if (wr_en)
		begin
			case (wr_addr)
				priv_pkg::csr_mstatus:
				begin
					status_sie  <= wr_data[1];
					status_mie  <= wr_data[3];
					status_spie <= wr_data[5];
					status_mpie <= wr_data[7];
					status_spp  <= wr_data[8];
					status_mpp  <= mpp_wr;
				end
				priv_pkg::csr_mie:
				begin
					stie <= wr_data[priv_pkg::irq_s_timer];
					mtie <= wr_data[priv_pkg::irq_m_timer];
					seie <= wr_data[priv_pkg::irq_s_ext];
					meie <= wr_data[priv_pkg::irq_m_ext];
				end
				priv_pkg::csr_mtvec:    mtvec <= wr_data[priv_pkg::xlen-1:2];
				priv_pkg::csr_mscratch: mscratch <= wr_data;
				priv_pkg::csr_mepc:     mepc <= wr_data[priv_pkg::xlen-1:2];
				priv_pkg::csr_mcause:   mcause <= wr_data;
				priv_pkg::csr_mtval:    mtval <= wr_data;
				priv_pkg::csr_medeleg:  medeleg <= wr_data[15:0];
				priv_pkg::csr_mideleg:  mideleg_r <= wr_data[11:0];
				priv_pkg::csr_sepc:     sepc <= wr_data[priv_pkg::xlen-1:2];
				priv_pkg::csr_scause:   scause <= wr_data;
				priv_pkg::csr_stval:    stval <= wr_data;
				default:
				begin
					// read-only or unknown, nothing stored
				end
			endcase
		end
	end

	// the pipeline retires at most one return per cycle
	assert property (@(posedge clk) disable iff (!nrst) !(mret && sret));

	// the top holds commands off while a trap or return is taken
	assert property (@(posedge clk) disable iff (!nrst) wr_en |-> !trap_busy);

endmodule

// ==== priv_top.sv ====
`timescale 1ns/1ps

module priv_top (
	input  logic clk,
	input  logic nrst,
	input  logic cmd_valid,
	input  priv_pkg::csr_op_t cmd_op,
	input  logic [11:0] cmd_addr,
	input  logic [priv_pkg::xlen-1:0] cmd_operand,
	output logic cmd_ready,
	output logic [priv_pkg::xlen-1:0] cmd_rdata,
	input  logic exc_valid,
	input  logic [priv_pkg::xlen-1:0] exc_cause,
	input  logic [priv_pkg::xlen-1:0] exc_pc,
	input  logic mret,
	input  logic sret,
	input  logic ext_m_irq,
	input  logic ext_s_irq,
	output logic trap_taken,
	output logic [priv_pkg::xlen-1:0] trap_pc,
	output priv_pkg::mode_t current_mode
);

	logic [priv_pkg::xlen-1:0] alu_wdata;
	logic alu_wen;
	logic trap_busy;
	logic [priv_pkg::xlen-1:0] cycle;
	logic m_timer;
	logic s_timer;
	logic [priv_pkg::xlen-1:0] mip;
	logic [priv_pkg::xlen-1:0] mie;
	logic [priv_pkg::xlen-1:0] mideleg;
	logic status_mie;
	logic status_sie;
	logic irq_valid;
	logic [priv_pkg::xlen-1:0] irq_cause;
	logic irq_to_s;

	// traps win over csr commands
	assign cmd_ready = !trap_busy;

	csr_alu u_alu (
		.op        (cmd_op),
		.operand   (cmd_operand),
		.old_value (cmd_rdata),			// value before the write
		.valid     (cmd_valid && cmd_ready),	// accepted this edge
		.wdata     (alu_wdata),
		.wen       (alu_wen)
	);

	csr_timer u_timer (
		.clk     (clk),
		.nrst    (nrst),
		.wr_en   (alu_wen),
		.wr_addr (cmd_addr),
		.wr_data (alu_wdata),
		.cycle   (cycle),
		.m_timer (m_timer),
		.s_timer (s_timer)
	);

	irq_select u_irq (
		.mip          (mip),
		.mie          (mie),
		.mideleg      (mideleg),
		.status_mie   (status_mie),
		.status_sie   (status_sie),
		.current_mode (current_mode),
		.irq_valid    (irq_valid),
		.irq_cause    (irq_cause),
		.irq_to_s     (irq_to_s)
	);

	csr_regfile u_regs (
		.clk          (clk),
		.nrst         (nrst),
		.rd_addr      (cmd_addr),
		.wr_en        (alu_wen),
		.wr_addr      (cmd_addr),
		.wr_data      (alu_wdata),
		.exc_valid    (exc_valid),
		.exc_cause    (exc_cause),
		.exc_pc       (exc_pc),
		.mret         (mret),
		.sret         (sret),
		.irq_valid    (irq_valid),
		.irq_cause    (irq_cause),
		.irq_to_s     (irq_to_s),
		.m_timer      (m_timer),
		.s_timer      (s_timer),
		.ext_m_irq    (ext_m_irq),
		.ext_s_irq    (ext_s_irq),
		.cycle        (cycle),
		.rd_data      (cmd_rdata),
		.mip          (mip),
		.mie          (mie),
		.mideleg      (mideleg),
		.status_mie   (status_mie),
		.status_sie   (status_sie),
		.current_mode (current_mode),
		.trap_busy    (trap_busy),
		.trap_taken   (trap_taken),
		.trap_pc      (trap_pc)
	);

endmodule

// ==== tb_priv_top.sv ====
`timescale 1ns/1ps

module tb_priv_top;

	localparam int max_steps = 64;
	localparam int reset_cycles = 16;

	logic clk;
	logic nrst;
	logic cmd_valid;
	priv_pkg::csr_op_t cmd_op;
	logic [11:0] cmd_addr;
	logic [31:0] cmd_operand;
	logic cmd_ready;
	logic [31:0] cmd_rdata;
	logic exc_valid;
	logic [31:0] exc_cause;
	logic [31:0] exc_pc;
	logic mret;
	logic sret;
	logic ext_m_irq;
	logic ext_s_irq;
	logic trap_taken;
	logic [31:0] trap_pc;
	priv_pkg::mode_t current_mode;

	// one entry per golden line
	int s_test [max_steps];
	logic [63:0] s_act [max_steps];
	logic [31:0] s_op [max_steps];
	logic [31:0] s_addr [max_steps];
	logic [31:0] s_operand [max_steps];
	logic [31:0] s_cause [max_steps];
	logic [31:0] s_pc [max_steps];
	logic [31:0] s_irq [max_steps];
	logic [31:0] s_rdata [max_steps];
	logic [31:0] s_ready [max_steps];
	logic [31:0] s_taken [max_steps];
	logic [31:0] s_tpc [max_steps];
	logic [31:0] s_mode [max_steps];

	int n_steps;
	int errors;
	int n_tests;
	int cycles = 0;
	int limit = 0;

	priv_top UUT (
		.clk          (clk),
		.nrst         (nrst),
		.cmd_valid    (cmd_valid),
		.cmd_op       (cmd_op),
		.cmd_addr     (cmd_addr),
		.cmd_operand  (cmd_operand),
		.cmd_ready    (cmd_ready),
		.cmd_rdata    (cmd_rdata),
		.exc_valid    (exc_valid),
		.exc_cause    (exc_cause),
		.exc_pc       (exc_pc),
		.mret         (mret),
		.sret         (sret),
		.ext_m_irq    (ext_m_irq),
		.ext_s_irq    (ext_s_irq),
		.trap_taken   (trap_taken),
		.trap_pc      (trap_pc),
		.current_mode (current_mode)
	);

	always #10 clk = ~clk;

	// run bound, set once the golden file is loaded
	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (limit > 0 && cycles >= limit)
		begin
			$display("timeout after %0d cycles, the run did not complete", cycles);
			$display("Test failed");
			$finish;
		end
	end

	task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
		$display("ERR t=%0t %s expected %h got %h", $time, name, exp, got);
		errors++;
	endtask

	task automatic drive_idle();
		cmd_valid = 1'b0;
		cmd_op = priv_pkg::CSR_RW;
		cmd_addr = '0;
		cmd_operand = '0;
		exc_valid = 1'b0;
		exc_cause = '0;
		exc_pc = '0;
		mret = 1'b0;
		sret = 1'b0;
		ext_m_irq = 1'b0;
		ext_s_irq = 1'b0;
	endtask

	task automatic load_golden(output logic ok);
		int fd;
		int t;
		string line;
		logic [63:0] act;
		logic [31:0] op;
		logic [31:0] addr;
		logic [31:0] operand;
		logic [31:0] cause;
		logic [31:0] pc;
		logic [31:0] irq;
		logic [31:0] rdata;
		logic [31:0] ready;
		logic [31:0] taken;
		logic [31:0] tpc;
		logic [31:0] mode;
		n_steps = 0;
		fd = $fopen("priv_golden.txt", "r");
		if (fd != 0)
		begin
			while (!$feof(fd) && n_steps < max_steps)
			begin
				line = "";
				if ($fgets(line, fd) > 0 && $sscanf(line,
					"%d %s %h %h %h %h %h %h %h %h %h %h %h", t, act, op, addr, operand,
					cause, pc, irq, rdata, ready, taken, tpc, mode) == 13)
				begin
					s_test[n_steps] = t;	// comment lines fail the scan
					s_act[n_steps] = act;
					s_op[n_steps] = op;
					s_addr[n_steps] = addr;
					s_operand[n_steps] = operand;
					s_cause[n_steps] = cause;
					s_pc[n_steps] = pc;
					s_irq[n_steps] = irq;
					s_rdata[n_steps] = rdata;
					s_ready[n_steps] = ready;
					s_taken[n_steps] = taken;
					s_tpc[n_steps] = tpc;
					s_mode[n_steps] = mode;
					n_steps++;
				end
			end
			$fclose(fd);
		end
		ok = (n_steps > 0);
	endtask

	task automatic run_step(input int i);
		int polls;
		logic timed_out;
		@(negedge clk);
		cmd_valid = (s_op[i] != 0);
		cmd_op = (s_op[i] != 0) ? priv_pkg::csr_op_t'(s_op[i][1:0]) : priv_pkg::CSR_RW;
		cmd_addr = s_addr[i][11:0];
		cmd_operand = s_operand[i];
		exc_valid = (s_act[i] == "exc");
		exc_cause = s_cause[i];
		exc_pc = s_pc[i];	// also the interrupted pc
		mret = (s_act[i] == "mret");
		sret = (s_act[i] == "sret");
		ext_m_irq = (s_act[i] == "irq") && s_irq[i][0];
		ext_s_irq = (s_act[i] == "irq") && s_irq[i][1];
		#5;
		timed_out = 1'b0;
		if (s_act[i] == "wait")
		begin
			polls = 0;
			while (!trap_taken && polls < s_operand[i])
			begin
				@(posedge clk);
				@(negedge clk);
				#5;
				polls++;
			end
			timed_out = !trap_taken;
		end
		if (timed_out)
		begin
			$display("step %0d: no trap was taken within %0d cycles", i, s_operand[i]);
			errors++;
		end
		else
		begin
			if (s_op[i] != 0 && cmd_rdata !== s_rdata[i])
				mismatch("cmd_rdata", s_rdata[i], cmd_rdata);
			if (cmd_ready !== s_ready[i][0])
				mismatch("cmd_ready", s_ready[i], {31'b0, cmd_ready});
			if (trap_taken !== s_taken[i][0])
				mismatch("trap_taken", s_taken[i], {31'b0, trap_taken});
			if (s_taken[i][0] && trap_pc !== s_tpc[i])
				mismatch("trap_pc", s_tpc[i], trap_pc);
			@(posedge clk);
			#1;
			// mode is registered, look after the edge
			if (current_mode !== s_mode[i][1:0])
				mismatch("current_mode", s_mode[i], {30'b0, current_mode});
		end
	endtask

	task automatic report_test(input int num, input int errs);
		if (errs == 0)
			$display("test %0d finished, no errors", num);
		else
			$display("test %0d finished with %0d errors", num, errs);
		n_tests++;
	endtask

	initial
	begin
		logic ok;
		int cur_test;
		int base;
		int bounds;
		clk = 1'b0;
		nrst = 1'b0;
		errors = 0;
		n_tests = 0;
		drive_idle();
		load_golden(ok);
		if (!ok)
		begin
			$display("golden file missing or holds no steps");
			$display("Test failed");
			$finish;
		end
		else
		begin
			bounds = 0;
			for (int i = 0; i < n_steps; i++)
				if (s_act[i] == "wait")
					bounds += s_operand[i];
			limit = reset_cycles + n_steps + bounds + 100;	// margin for idle edges
			repeat (reset_cycles) @(posedge clk);
			@(negedge clk);
			nrst = 1'b1;
			cur_test = s_test[0];
			base = 0;
			for (int i = 0; i < n_steps; i++)
			begin
				if (s_test[i] != cur_test)
				begin
					report_test(cur_test, errors - base);
					cur_test = s_test[i];
					base = errors;
				end
				run_step(i);
			end
			report_test(cur_test, errors - base);
			@(negedge clk);
			drive_idle();
			$display("%0d tests, %0d steps, %0d errors", n_tests, n_steps, errors);
			if (errors == 0)
				$display("Test passed");
			else
				$display("Test failed");
			$finish;
		end
	end

endmodule

// ==== priv_golden.txt ====
# test action op addr operand cause pc irq | rdata ready taken trap_pc mode, all hex but test
# op 1 rw, 2 rs, 3 rc, 0 no command; a wait line holds its cycle bound in operand
1 cmd  1 340 12345678 00 00000000 0 00000000 1 0 00000000 3
1 cmd  2 340 0000f000 00 00000000 0 12345678 1 0 00000000 3
1 cmd  3 340 00000078 00 00000000 0 1234f678 1 0 00000000 3
1 cmd  2 340 00000000 00 00000000 0 1234f600 1 0 00000000 3
1 cmd  2 340 00000000 00 00000000 0 1234f600 1 0 00000000 3
1 cmd  2 301 00000000 00 00000000 0 40040100 1 0 00000000 3
1 cmd  2 f14 00000000 00 00000000 0 00000000 1 0 00000000 3
1 cmd  1 341 00002003 00 00000000 0 00000000 1 0 00000000 3
1 cmd  2 341 00000000 00 00000000 0 00002000 1 0 00000000 3
2 cmd  1 305 00000100 00 00000000 0 00000000 1 0 00000000 3
2 exc  0 000 00000000 0b 00000400 0 00000000 0 1 00000100 3
2 cmd  2 341 00000000 00 00000000 0 00000400 1 0 00000000 3
2 cmd  2 342 00000000 00 00000000 0 0000000b 1 0 00000000 3
2 cmd  2 300 00000000 00 00000000 0 00001800 1 0 00000000 3
2 mret 0 000 00000000 00 00000000 0 00000000 0 1 00000400 3
2 cmd  2 300 00000000 00 00000000 0 00000080 1 0 00000000 3
3 cmd  1 302 00000100 00 00000000 0 00000000 1 0 00000000 3
3 cmd  1 300 00000000 00 00000000 0 00000080 1 0 00000000 3
3 cmd  1 341 00000800 00 00000000 0 00000400 1 0 00000000 3
3 mret 0 000 00000000 00 00000000 0 00000000 0 1 00000800 0
3 exc  0 000 00000000 08 00000804 0 00000000 0 1 00000100 1
3 cmd  2 141 00000000 00 00000000 0 00000804 1 0 00000000 1
3 cmd  2 142 00000000 00 00000000 0 00000008 1 0 00000000 1
3 cmd  2 342 00000000 00 00000000 0 0000000b 1 0 00000000 1
3 sret 0 000 00000000 00 00000000 0 00000000 0 1 00000804 0
3 exc  0 000 00000000 03 00000808 0 00000000 0 1 00000100 3
4 cmd  1 304 00000800 00 00000000 0 00000000 1 0 00000000 3
4 cmd  2 300 00000008 00 00000000 0 00000020 1 0 00000000 3
4 irq  0 000 00000000 00 00000900 1 00000000 0 1 00000100 3
4 cmd  2 342 00000000 00 00000000 0 8000000b 1 0 00000000 3
4 cmd  2 341 00000000 00 00000000 0 00000900 1 0 00000000 3
4 irq  0 000 00000000 00 00000904 1 00000000 1 0 00000000 3
4 cmd  2 300 00000000 00 00000000 0 000018a0 1 0 00000000 3
5 cmd  1 7c0 00000080 00 00000000 0 00000000 1 0 00000000 3
5 cmd  2 304 00000080 00 00000000 0 00000800 1 0 00000000 3
5 cmd  2 300 00000008 00 00000000 0 000018a0 1 0 00000000 3
5 wait 0 000 00000100 00 00000a00 0 00000000 0 1 00000100 3
5 cmd  2 342 00000000 00 00000000 0 80000007 1 0 00000000 3
5 cmd  2 341 00000000 00 00000000 0 00000a00 1 0 00000000 3
6 exc  1 342 00000000 02 00000b00 0 80000007 0 1 00000100 3
6 cmd  1 342 00000000 00 00000000 0 00000002 1 0 00000000 3
6 cmd  2 342 00000000 00 00000000 0 00000000 1 0 00000000 3
6 cmd  2 341 00000000 00 00000000 0 00000b00 1 0 00000000 3

// ==== src.f ====
priv_pkg.sv
csr_alu.sv
csr_timer.sv
irq_select.sv
csr_regfile.sv
priv_top.sv
tb_priv_top.sv
